// File: design/cce_cmd_out.sv
// Outbound command header register
`timescale 1ns/1ps

module cce_cmd_out
  (input                                  clk_i
   , input                                reset_i
   , input                                send_v_i
   , input cce_pkg::cce_lce_cmd_s         cmd_i
   , input                                lce_cmd_header_ready_and_i
   , output logic                         cmd_full_o
   , output cce_pkg::cce_lce_cmd_s        lce_cmd_header_o
   , output logic                         lce_cmd_header_v_o
  );

  cce_pkg::cce_lce_cmd_s cmd_q;
  logic                  full_r;

  assign cmd_full_o         = full_r;
  assign lce_cmd_header_o   = cmd_q;
  assign lce_cmd_header_v_o = full_r;

  // Execute never sends while full, so load and drain never coincide
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_r <= 1'b0;
    end else if (send_v_i) begin
      full_r <= 1'b1;
    end else if (lce_cmd_header_ready_and_i) begin
      full_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (send_v_i) begin
      cmd_q <= cmd_i;
    end
  end

endmodule

// File: design/cce_execute.sv
// Execute stage with request buffer and registers
`timescale 1ns/1ps

module cce_execute
  (input                                    clk_i
   , input                                  reset_i

   , input cce_pkg::cce_decoded_s           decoded_i
   , input [cce_pkg::PC_WIDTH-1:0]          ex_pc_i

   , input cce_pkg::cce_lce_req_s           lce_req_header_i
   , input                                  lce_req_header_v_i
   , output logic                           lce_req_header_ready_and_o

   , input                                  pending_i
   , input                                  cmd_full_i

   , output logic [cce_pkg::ADDR_WIDTH-1:0] pend_addr_o
   , output logic                           pend_r_v_o
   , output logic                           pend_w_v_o
   , output logic                           pend_val_o

   , output logic                           send_v_o
   , output cce_pkg::cce_lce_cmd_s          cmd_o

   , output logic                           stall_o
   , output logic                           mispredict_o
   , output logic [cce_pkg::PC_WIDTH-1:0]   resolve_pc_o
  );

  logic [cce_pkg::GPR_WIDTH-1:0] gpr_r [cce_pkg::NUM_GPR];
  logic [cce_pkg::GPR_WIDTH-1:0] src_a_val, src_b_reg, src_b_val;
  logic [cce_pkg::GPR_WIDTH-1:0] alu_res, wdata;
  cce_pkg::cce_lce_req_s         req_q, req_view;
  logic                          req_full, req_yumi;
  logic                          taken;

  assign src_a_val = gpr_r[decoded_i.src_a];
  assign src_b_reg = gpr_r[decoded_i.src_b];
  assign src_b_val = decoded_i.use_imm
                   ? {{(cce_pkg::GPR_WIDTH-cce_pkg::IMM_WIDTH){1'b0}}, decoded_i.imm}
                   : src_b_reg;
  assign req_view  = src_a_val;

  assign alu_res = (decoded_i.alu_op == cce_pkg::OP_AND) ? (src_a_val & src_b_val)
                                                         : (src_a_val + src_b_val);

  assign stall_o = (decoded_i.popq_v && !req_full) || (decoded_i.send_v && cmd_full_i);

  // Branch resolution against the predecode guess
  always_comb begin
    unique case (decoded_i.branch_op)
      cce_pkg::OP_BEQ: taken = (src_a_val == src_b_reg);
      cce_pkg::OP_BNE: taken = (src_a_val != src_b_reg);
      default:         taken = 1'b1;
    endcase
  end
  assign mispredict_o = decoded_i.branch && (taken != decoded_i.predict_taken);
  assign resolve_pc_o = taken ? decoded_i.target : ex_pc_i + 1'b1;

  // Pending table access uses the request address held in src_a
  assign pend_addr_o = req_view.addr;
  assign pend_r_v_o  = decoded_i.pend_r_v;
  assign pend_w_v_o  = decoded_i.pend_w_v && !stall_o;
  assign pend_val_o  = decoded_i.pend_val;

  assign send_v_o       = decoded_i.send_v && !stall_o;
  assign cmd_o.cmd_type = decoded_i.cmd_type;
  assign cmd_o.lce_id   = req_view.lce_id;
  assign cmd_o.addr     = req_view.addr;
  assign cmd_o.seq      = src_b_reg[cce_pkg::SEQ_WIDTH-1:0];

  always_comb begin
    if (decoded_i.alu_v) begin
      wdata = alu_res;
    end else if (decoded_i.popq_v) begin
      wdata = req_q;
    end else begin
      wdata = {{(cce_pkg::GPR_WIDTH-1){1'b0}}, pending_i};
    end
  end

  // One-entry inbound buffer that is ready only while empty
  assign lce_req_header_ready_and_o = !req_full;
  assign req_yumi = decoded_i.popq_v && req_full;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_full <= 1'b0;
    end else if (lce_req_header_v_i && !req_full) begin
      req_full <= 1'b1;
    end else if (req_yumi) begin
      req_full <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lce_req_header_v_i && !req_full) begin
      req_q <= lce_req_header_i;
    end
  end

  // r0 is never written
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < cce_pkg::NUM_GPR; i++) begin
        gpr_r[i] <= '0;
      end
    end else if (decoded_i.gpr_w_v && !stall_o && (decoded_i.dst != '0)) begin
      gpr_r[decoded_i.dst] <= wdata;
    end
  end

endmodule

// File: design/cce_inst_decode.sv
// Microcode instruction decoder
`timescale 1ns/1ps

module cce_inst_decode
  (input                                  clk_i
   , input                                reset_i
   , input cce_pkg::cce_inst_u            fetch_inst_i
   , input [cce_pkg::PC_WIDTH-1:0]        fetch_pc_i
   , input                                fetch_v_i
   , input                                stall_i
   , input                                mispredict_i
   , output cce_pkg::cce_decoded_s        decoded_o
   , output logic [cce_pkg::PC_WIDTH-1:0] ex_pc_o
  );

  cce_pkg::cce_decoded_s dec;

  always_comb begin
    dec = '0;
    unique case (fetch_inst_i.alu.opcode)
      cce_pkg::OP_ADD, cce_pkg::OP_AND: begin
        dec.alu_v   = 1'b1;
        dec.alu_op  = fetch_inst_i.alu.opcode;
        dec.dst     = fetch_inst_i.alu.dst;
        dec.src_a   = fetch_inst_i.alu.src_a;
        dec.src_b   = fetch_inst_i.alu.src_b;
        dec.use_imm = fetch_inst_i.alu.use_imm;
        dec.imm     = fetch_inst_i.alu.imm;
        dec.gpr_w_v = 1'b1;
      end
      cce_pkg::OP_BEQ, cce_pkg::OP_BNE, cce_pkg::OP_BI: begin
        dec.branch        = 1'b1;
        dec.branch_op     = fetch_inst_i.br.opcode;
        dec.src_a         = fetch_inst_i.br.src_a;
        dec.src_b         = fetch_inst_i.br.src_b;
        // Predecode always redirects on BI
        dec.predict_taken = fetch_inst_i.br.predict_taken
                         || (fetch_inst_i.br.opcode == cce_pkg::OP_BI);
        dec.target        = fetch_inst_i.br.target;
      end
      cce_pkg::OP_POPQ: begin
        dec.popq_v  = 1'b1;
        dec.dst     = fetch_inst_i.alu.dst;
        dec.gpr_w_v = 1'b1;
      end
      cce_pkg::OP_RDP: begin
        dec.pend_r_v = 1'b1;
        dec.src_a    = fetch_inst_i.alu.src_a;
        dec.dst      = fetch_inst_i.alu.dst;
        dec.gpr_w_v  = 1'b1;
      end
      cce_pkg::OP_WRP: begin
        dec.pend_w_v = 1'b1;
        dec.src_a    = fetch_inst_i.alu.src_a;
        dec.pend_val = fetch_inst_i.alu.imm[0];
      end
      cce_pkg::OP_SENDC: begin
        dec.send_v   = 1'b1;
        dec.src_a    = fetch_inst_i.alu.src_a;
        dec.src_b    = fetch_inst_i.alu.src_b;
        dec.cmd_type = fetch_inst_i.alu.imm[cce_pkg::CMD_TYPE_WIDTH-1:0];
      end
      default: begin
        dec = '0;
      end
    endcase
  end

  // Hold under stall, squash on redirect or empty fetch
  always_ff @(posedge clk_i) begin
    if (reset_i || mispredict_i) begin
      decoded_o <= '0;
      ex_pc_o   <= '0;
    end else if (!stall_i) begin
      decoded_o <= fetch_v_i ? dec : '0;
      ex_pc_o   <= fetch_pc_i;
    end
  end

endmodule

// File: design/cce_inst_ram.sv
// Microcode store and fetch
`timescale 1ns/1ps

module cce_inst_ram
  (input                                    clk_i
   , input                                  reset_i
   , input                                  run_i

   , input                                  ucode_v_i
   , input                                  ucode_w_i
   , input [cce_pkg::PC_WIDTH-1:0]          ucode_addr_i
   , input [cce_pkg::INST_WIDTH-1:0]        ucode_data_i
   , output logic [cce_pkg::INST_WIDTH-1:0] ucode_data_o

   , input                                  stall_i
   , input                                  mispredict_i
   , input [cce_pkg::PC_WIDTH-1:0]          resolve_pc_i

   , output logic [cce_pkg::PC_WIDTH-1:0]   fetch_pc_o
   , output cce_pkg::cce_inst_u             fetch_inst_o
   , output logic                           fetch_v_o
  );

  logic [cce_pkg::INST_WIDTH-1:0] mem_r [2**cce_pkg::PC_WIDTH];
  logic [cce_pkg::PC_WIDTH-1:0]   pred_pc;
  logic [cce_pkg::PC_WIDTH-1:0]   rd_addr;
  logic                           pred_taken;

  // Predecode of the word now in fetch
  assign pred_taken = (fetch_inst_o.br.opcode == cce_pkg::OP_BI)
                   || (((fetch_inst_o.br.opcode == cce_pkg::OP_BEQ)
                     || (fetch_inst_o.br.opcode == cce_pkg::OP_BNE))
                     && fetch_inst_o.br.predict_taken);
  assign pred_pc = pred_taken ? fetch_inst_o.br.target : fetch_pc_o + 1'b1;

  // Without a valid word the PC register already holds the next address
  assign rd_addr = fetch_v_o ? pred_pc : fetch_pc_o;

  // Programming port with synchronous readback
  always_ff @(posedge clk_i) begin
    if (ucode_v_i && ucode_w_i) begin
      mem_r[ucode_addr_i] <= ucode_data_i;
    end
    if (ucode_v_i && !ucode_w_i) begin
      ucode_data_o <= mem_r[ucode_addr_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (run_i && !stall_i && !mispredict_i) begin
      fetch_inst_o <= mem_r[rd_addr];
    end
  end

  // A redirect drops fetch for one cycle while the new word is read
  always_ff @(posedge clk_i) begin
    if (reset_i || !run_i) begin
      fetch_pc_o <= '0;
      fetch_v_o  <= 1'b0;
    end else if (mispredict_i) begin
      fetch_pc_o <= resolve_pc_i;
      fetch_v_o  <= 1'b0;
    end else if (!stall_i) begin
      fetch_pc_o <= rd_addr;
      fetch_v_o  <= 1'b1;
    end
  end

endmodule

// File: design/cce_pending_bits.sv
// Per-set pending bit table
`timescale 1ns/1ps

module cce_pending_bits
  (input                                  clk_i
   , input                                reset_i
   , input [cce_pkg::ADDR_WIDTH-1:0]      addr_i
   , input                                r_v_i
   , input                                w_v_i
   , input                                val_i
   , output logic                         pending_o
  );

  logic [cce_pkg::PENDING_SETS-1:0]      bits_r;
  logic [cce_pkg::PENDING_IDX_WIDTH-1:0] idx;

  // Set index from the bits just above the block offset
  assign idx = addr_i[cce_pkg::BLOCK_OFFSET +: cce_pkg::PENDING_IDX_WIDTH];

  assign pending_o = r_v_i && bits_r[idx];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bits_r <= '0;
    end else if (w_v_i) begin
      bits_r[idx] <= val_i;
    end
  end

endmodule

// File: design/cce_pkg.sv
// Coherence engine shared types
package cce_pkg;

  // Microcode store
  localparam int PC_WIDTH   = 8;
  localparam int INST_WIDTH = 32;
  localparam int OP_WIDTH   = 4;
  localparam int IMM_WIDTH  = 16;

  // Register file
  localparam int GPR_WIDTH     = 32;
  localparam int NUM_GPR       = 8;
  localparam int GPR_SEL_WIDTH = 3;

  // Request and command fields
  localparam int ADDR_WIDTH     = 27;
  localparam int LCE_ID_WIDTH   = 4;
  localparam int CMD_TYPE_WIDTH = 4;
  localparam int SEQ_WIDTH      = 8;

  // Pending table geometry
  localparam int BLOCK_OFFSET      = 6;
  localparam int PENDING_SETS      = 16;
  localparam int PENDING_IDX_WIDTH = $clog2(PENDING_SETS);

  // Command types sent to the LCE
  localparam logic [CMD_TYPE_WIDTH-1:0] CMD_GRANT = 4'd1;
  localparam logic [CMD_TYPE_WIDTH-1:0] CMD_NACK  = 4'd2;
  localparam logic [CMD_TYPE_WIDTH-1:0] CMD_ACK   = 4'd3;

  // Opcode 0 is left unassigned and decodes as a bubble
  typedef enum logic [OP_WIDTH-1:0] {
    OP_ADD   = 4'd1,
    OP_AND   = 4'd2,
    OP_BEQ   = 4'd3,
    OP_BNE   = 4'd4,
    OP_BI    = 4'd5,
    OP_POPQ  = 4'd6,
    OP_RDP   = 4'd7,
    OP_WRP   = 4'd8,
    OP_SENDC = 4'd9
  } cce_op_e;

  // ALU, queue, pending and send instructions
  typedef struct packed {
    cce_op_e                  opcode;
    logic [GPR_SEL_WIDTH-1:0] dst;
    logic [GPR_SEL_WIDTH-1:0] src_a;
    logic [GPR_SEL_WIDTH-1:0] src_b;
    logic                     use_imm;
    logic [1:0]               pad;
    logic [IMM_WIDTH-1:0]     imm;
  } cce_alu_fmt_s;

  // Branch instructions
  typedef struct packed {
    cce_op_e                  opcode;
    logic [GPR_SEL_WIDTH-1:0] src_a;
    logic [GPR_SEL_WIDTH-1:0] src_b;
    logic                     predict_taken;
    logic [PC_WIDTH-1:0]      target;
    logic [12:0]              pad;
  } cce_br_fmt_s;

  // Opcode sits in the same bits of both views
  typedef union packed {
    cce_alu_fmt_s alu;
    cce_br_fmt_s  br;
  } cce_inst_u;

  typedef struct packed {
    logic                      alu_v;
    cce_op_e                   alu_op;
    logic [GPR_SEL_WIDTH-1:0]  dst;
    logic [GPR_SEL_WIDTH-1:0]  src_a;
    logic [GPR_SEL_WIDTH-1:0]  src_b;
    logic                      use_imm;
    logic [IMM_WIDTH-1:0]      imm;
    logic                      branch;
    cce_op_e                   branch_op;
    logic                      predict_taken;
    logic [PC_WIDTH-1:0]       target;
    logic                      popq_v;
    logic                      pend_r_v;
    logic                      pend_w_v;
    logic                      pend_val;
    logic                      send_v;
    logic [CMD_TYPE_WIDTH-1:0] cmd_type;
    logic                      gpr_w_v;
  } cce_decoded_s;

  // Request type in bit 0 so a small immediate can mask it
  typedef struct packed {
    logic [ADDR_WIDTH-1:0]   addr;
    logic [LCE_ID_WIDTH-1:0] lce_id;
    logic                    req_type;
  } cce_lce_req_s;

  typedef struct packed {
    logic [CMD_TYPE_WIDTH-1:0] cmd_type;
    logic [LCE_ID_WIDTH-1:0]   lce_id;
    logic [ADDR_WIDTH-1:0]     addr;
    logic [SEQ_WIDTH-1:0]      seq;
  } cce_lce_cmd_s;

endpackage

// File: design/cce_top.sv
// Coherence engine top level
`timescale 1ns/1ps

module cce_top
  (input                                    clk_i
   , input                                  reset_i
   , input                                  run_i

   // Microcode programming, synchronous read
   , input                                  ucode_v_i
   , input                                  ucode_w_i
   , input [cce_pkg::PC_WIDTH-1:0]          ucode_addr_i
   , input [cce_pkg::INST_WIDTH-1:0]        ucode_data_i
   , output logic [cce_pkg::INST_WIDTH-1:0] ucode_data_o

   // LCE request header, ready&valid
   , input cce_pkg::cce_lce_req_s           lce_req_header_i
   , input                                  lce_req_header_v_i
   , output logic                           lce_req_header_ready_and_o

   // LCE command header, ready&valid
   , output cce_pkg::cce_lce_cmd_s          lce_cmd_header_o
   , output logic                           lce_cmd_header_v_o
   , input                                  lce_cmd_header_ready_and_i
  );

  logic [cce_pkg::PC_WIDTH-1:0]   fetch_pc, ex_pc, resolve_pc;
  cce_pkg::cce_inst_u             fetch_inst;
  logic                           fetch_v;
  cce_pkg::cce_decoded_s          decoded;
  logic                           stall, mispredict;
  logic [cce_pkg::ADDR_WIDTH-1:0] pend_addr;
  logic                           pend_r_v, pend_w_v, pend_val, pending;
  logic                           send_v, cmd_full;
  cce_pkg::cce_lce_cmd_s          cmd;

  cce_inst_ram
    inst_ram
     (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.run_i(run_i)
      ,.ucode_v_i(ucode_v_i)
      ,.ucode_w_i(ucode_w_i)
      ,.ucode_addr_i(ucode_addr_i)
      ,.ucode_data_i(ucode_data_i)
      ,.ucode_data_o(ucode_data_o)
      ,.stall_i(stall)
      ,.mispredict_i(mispredict)
      ,.resolve_pc_i(resolve_pc)
      ,.fetch_pc_o(fetch_pc)
      ,.fetch_inst_o(fetch_inst)
      ,.fetch_v_o(fetch_v)
      );

  cce_inst_decode
    inst_decode
     (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.fetch_inst_i(fetch_inst)
      ,.fetch_pc_i(fetch_pc)
      ,.fetch_v_i(fetch_v)
      ,.stall_i(stall)
      ,.mispredict_i(mispredict)
      ,.decoded_o(decoded)
      ,.ex_pc_o(ex_pc)
      );

  cce_execute
    execute
     (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.decoded_i(decoded)
      ,.ex_pc_i(ex_pc)
      ,.lce_req_header_i(lce_req_header_i)
      ,.lce_req_header_v_i(lce_req_header_v_i)
      ,.lce_req_header_ready_and_o(lce_req_header_ready_and_o)
      ,.pending_i(pending)
      ,.cmd_full_i(cmd_full)
      ,.pend_addr_o(pend_addr)
      ,.pend_r_v_o(pend_r_v)
      ,.pend_w_v_o(pend_w_v)
      ,.pend_val_o(pend_val)
      ,.send_v_o(send_v)
      ,.cmd_o(cmd)
      ,.stall_o(stall)
      ,.mispredict_o(mispredict)
      ,.resolve_pc_o(resolve_pc)
      );

  cce_pending_bits
    pending_bits
     (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.addr_i(pend_addr)
      ,.r_v_i(pend_r_v)
      ,.w_v_i(pend_w_v)
      ,.val_i(pend_val)
      ,.pending_o(pending)
      );

  cce_cmd_out
    cmd_out
     (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.send_v_i(send_v)
      ,.cmd_i(cmd)
      ,.lce_cmd_header_ready_and_i(lce_cmd_header_ready_and_i)
      ,.cmd_full_o(cmd_full)
      ,.lce_cmd_header_o(lce_cmd_header_o)
      ,.lce_cmd_header_v_o(lce_cmd_header_v_o)
      );

endmodule

// File: project.f
design/cce_pkg.sv
design/cce_inst_ram.sv
design/cce_inst_decode.sv
design/cce_execute.sv
design/cce_pending_bits.sv
design/cce_cmd_out.sv
design/cce_top.sv
sim/cce_props.sv
sim/cce_checker.sv
sim/cce_tb.sv

// File: sim/cce_checker.sv
// Command and readback checker
`timescale 1ns/1ps

module cce_checker
  (input                               clk_i
   , input                             reset_i
   , input                             ucode_v_i
   , input                             ucode_w_i
   , input [cce_pkg::PC_WIDTH-1:0]     ucode_addr_i
   , input [cce_pkg::INST_WIDTH-1:0]   ucode_wdata_i
   , input [cce_pkg::INST_WIDTH-1:0]   ucode_rdata_i
   , input                             req_v_i
   , input                             req_ready_i
   , input cce_pkg::cce_lce_cmd_s      exp_cmd_i
   , input cce_pkg::cce_lce_cmd_s      cmd_hdr_i
   , input                             cmd_v_i
   , input                             cmd_ready_i
   , output int                        mismatch_count_o
   , output int                        error_count_o
   , output int                        cmd_count_o
  );

  logic [cce_pkg::INST_WIDTH-1:0] shadow [2**cce_pkg::PC_WIDTH];
  cce_pkg::cce_lce_cmd_s          exp_q [$];
  cce_pkg::cce_lce_cmd_s          exp;
  cce_pkg::cce_lce_cmd_s          held_hdr;
  logic [cce_pkg::PC_WIDTH-1:0]   rd_addr;
  logic                           rd_pend, held, req_taken, was_reset;

  task automatic check_field(input string name, input logic [63:0] got,
                             input logic [63:0] want);
    if (got !== want) begin
      mismatch_count_o++;
      $display("mismatch %s: got %h expected %h", name, got, want);
    end
  endtask

  initial begin
    mismatch_count_o = 0;
    error_count_o    = 0;
    cmd_count_o      = 0;
    rd_pend          = 1'b0;
    held             = 1'b0;
    req_taken        = 1'b0;
    was_reset        = 1'b0;
  end

  always @(posedge clk_i) begin
    if (was_reset) begin
      check_field("lce_cmd_header_v_o", cmd_v_i, 1'b0);
      check_field("lce_req_header_ready_and_o", req_ready_i, 1'b1);
    end
    if (!reset_i) begin
      if (rd_pend) begin
        check_field("ucode_data_o", ucode_rdata_i, shadow[rd_addr]);
      end
      // Header must not move while the LCE holds it off
      if (held) begin
        check_field("lce_cmd_header_v_o", cmd_v_i, 1'b1);
        check_field("lce_cmd_header_o", cmd_hdr_i, held_hdr);
      end
      if (req_taken) begin
        check_field("lce_req_header_ready_and_o", req_ready_i, 1'b0);
      end
      if (req_v_i && req_ready_i) begin
        exp_q.push_back(exp_cmd_i);
      end
      if (cmd_v_i && cmd_ready_i) begin
        cmd_count_o++;
        if (exp_q.size() == 0) begin
          error_count_o++;
          $display("command sent with no request outstanding");
        end else begin
          exp = exp_q.pop_front();
          check_field("lce_cmd_header_o.cmd_type", cmd_hdr_i.cmd_type, exp.cmd_type);
          check_field("lce_cmd_header_o.lce_id", cmd_hdr_i.lce_id, exp.lce_id);
          check_field("lce_cmd_header_o.addr", cmd_hdr_i.addr, exp.addr);
          check_field("lce_cmd_header_o.seq", cmd_hdr_i.seq, exp.seq);
        end
      end
      if (ucode_v_i && ucode_w_i) begin
        shadow[ucode_addr_i] = ucode_wdata_i;
      end
    end
    rd_pend   = !reset_i && ucode_v_i && !ucode_w_i;
    rd_addr   = ucode_addr_i;
    held      = !reset_i && cmd_v_i && !cmd_ready_i;
    held_hdr  = cmd_hdr_i;
    req_taken = !reset_i && req_v_i && req_ready_i;
    was_reset = reset_i;
  end

endmodule

// File: sim/cce_props.sv
// Command and request handshake assertions
`timescale 1ns/1ps

module cce_props
  (input                          clk_i
   , input                        reset_i
   , input cce_pkg::cce_lce_cmd_s cmd_hdr_i
   , input                        cmd_v_i
   , input                        cmd_ready_i
   , input                        req_v_i
   , input                        req_ready_i
  );

  // Header and valid hold until the transfer edge
  cmd_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    cmd_v_i && !cmd_ready_i |=> cmd_v_i && $stable(cmd_hdr_i))
    else $error("command header changed or dropped before transfer");

  // Idle port state out of reset
  reset_state: assert property (@(posedge clk_i)
    reset_i |=> !cmd_v_i && req_ready_i)
    else $error("command valid or request ready wrong after reset");

  // One-entry buffer is full after an accepted request
  req_fill: assert property (@(posedge clk_i) disable iff (reset_i)
    req_v_i && req_ready_i |=> !req_ready_i)
    else $error("request ready stayed high with a request buffered");

endmodule

bind cce_top cce_props u_props
  (.clk_i(clk_i)
   ,.reset_i(reset_i)
   ,.cmd_hdr_i(lce_cmd_header_o)
   ,.cmd_v_i(lce_cmd_header_v_o)
   ,.cmd_ready_i(lce_cmd_header_ready_and_i)
   ,.req_v_i(lce_req_header_v_i)
   ,.req_ready_i(lce_req_header_ready_and_o)
   );

// File: sim/cce_tb.sv
// Coherence engine testbench
`timescale 1ns/1ps

module cce_tb;

  localparam int WAIT_LIMIT = 200;
  localparam int DONE_LIMIT = 2000;
  localparam int L_NACK     = 9;
  localparam int L_REL      = 11;

  // One request and the command it should produce
  typedef struct packed {
    cce_pkg::cce_lce_req_s req;
    cce_pkg::cce_lce_cmd_s exp;
  } req_entry_s;

  logic                           clk, reset, run;
  logic                           ucode_v, ucode_w;
  logic [cce_pkg::PC_WIDTH-1:0]   ucode_addr;
  logic [cce_pkg::INST_WIDTH-1:0] ucode_wdata, ucode_rdata;
  cce_pkg::cce_lce_req_s          req_hdr;
  logic                           req_v, req_ready;
  cce_pkg::cce_lce_cmd_s          exp_cmd, cmd_hdr;
  logic                           cmd_v, cmd_ready, ready_bit;
  int                             mismatches, errors, cmds, timeouts;
  logic [31:0]                    gap_lfsr, ready_lfsr;
  logic [cce_pkg::INST_WIDTH-1:0] ucode_tab [$];
  req_entry_s                     req_tab [$];

  cce_top u_dut
    (.clk_i(clk)
     ,.reset_i(reset)
     ,.run_i(run)
     ,.ucode_v_i(ucode_v)
     ,.ucode_w_i(ucode_w)
     ,.ucode_addr_i(ucode_addr)
     ,.ucode_data_i(ucode_wdata)
     ,.ucode_data_o(ucode_rdata)
     ,.lce_req_header_i(req_hdr)
     ,.lce_req_header_v_i(req_v)
     ,.lce_req_header_ready_and_o(req_ready)
     ,.lce_cmd_header_o(cmd_hdr)
     ,.lce_cmd_header_v_o(cmd_v)
     ,.lce_cmd_header_ready_and_i(cmd_ready)
     );

  cce_checker u_checker
    (.clk_i(clk)
     ,.reset_i(reset)
     ,.ucode_v_i(ucode_v)
     ,.ucode_w_i(ucode_w)
     ,.ucode_addr_i(ucode_addr)
     ,.ucode_wdata_i(ucode_wdata)
     ,.ucode_rdata_i(ucode_rdata)
     ,.req_v_i(req_v)
     ,.req_ready_i(req_ready)
     ,.exp_cmd_i(exp_cmd)
     ,.cmd_hdr_i(cmd_hdr)
     ,.cmd_v_i(cmd_v)
     ,.cmd_ready_i(cmd_ready)
     ,.mismatch_count_o(mismatches)
     ,.error_count_o(errors)
     ,.cmd_count_o(cmds)
     );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Fibonacci LFSR with taps 32 22 2 1 shifting into bit 0
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] alu_word(input cce_pkg::cce_op_e op,
      input logic [2:0] dst, input logic [2:0] src_a, input logic [2:0] src_b,
      input logic use_imm, input logic [15:0] imm);
    cce_pkg::cce_alu_fmt_s f;
    f         = '0;
    f.opcode  = op;
    f.dst     = dst;
    f.src_a   = src_a;
    f.src_b   = src_b;
    f.use_imm = use_imm;
    f.imm     = imm;
    return f;
  endfunction

  function automatic logic [31:0] br_word(input cce_pkg::cce_op_e op,
      input logic [2:0] src_a, input logic [2:0] src_b, input logic predict,
      input logic [7:0] target);
    cce_pkg::cce_br_fmt_s f;
    f               = '0;
    f.opcode        = op;
    f.src_a         = src_a;
    f.src_b         = src_b;
    f.predict_taken = predict;
    f.target        = target;
    return f;
  endfunction

  task automatic add_req(input logic [3:0] id, input logic [26:0] addr, input logic rel,
                         input logic [3:0] cmd_type, input logic [7:0] seq);
    req_entry_s e;
    e.req.lce_id   = id;
    e.req.addr     = addr;
    e.req.req_type = rel;
    e.exp.cmd_type = cmd_type;
    e.exp.lce_id   = id;
    e.exp.addr     = addr;
    e.exp.seq      = seq;
    req_tab.push_back(e);
  endtask

  task automatic build_tables();
    // r1 request, r2 pending bit, r3 release flag, r4 grant count
    ucode_tab.push_back(alu_word(cce_pkg::OP_POPQ, 1, 0, 0, 0, 0));
    ucode_tab.push_back(alu_word(cce_pkg::OP_AND, 3, 1, 0, 1, 1));
    ucode_tab.push_back(br_word(cce_pkg::OP_BNE, 3, 0, 0, L_REL));
    ucode_tab.push_back(alu_word(cce_pkg::OP_RDP, 2, 1, 0, 0, 0));
    ucode_tab.push_back(br_word(cce_pkg::OP_BNE, 2, 0, 0, L_NACK));
    ucode_tab.push_back(alu_word(cce_pkg::OP_WRP, 0, 1, 0, 0, 1));
    ucode_tab.push_back(alu_word(cce_pkg::OP_ADD, 4, 4, 0, 1, 1));
    ucode_tab.push_back(alu_word(cce_pkg::OP_SENDC, 0, 1, 4, 0, cce_pkg::CMD_GRANT));
    ucode_tab.push_back(br_word(cce_pkg::OP_BI, 0, 0, 1, 0));
    ucode_tab.push_back(alu_word(cce_pkg::OP_SENDC, 0, 1, 4, 0, cce_pkg::CMD_NACK));
    ucode_tab.push_back(br_word(cce_pkg::OP_BI, 0, 0, 1, 0));
    ucode_tab.push_back(alu_word(cce_pkg::OP_WRP, 0, 1, 0, 0, 0));
    ucode_tab.push_back(alu_word(cce_pkg::OP_SENDC, 0, 1, 4, 0, cce_pkg::CMD_ACK));
    ucode_tab.push_back(br_word(cce_pkg::OP_BI, 0, 0, 1, 0));
    // Set index is addr[9:6]
    add_req(4'd1, 27'h0000040, 1'b0, cce_pkg::CMD_GRANT, 8'd1);
    add_req(4'd2, 27'h0000080, 1'b0, cce_pkg::CMD_GRANT, 8'd2);
    add_req(4'd3, 27'h0001040, 1'b0, cce_pkg::CMD_NACK, 8'd2);
    add_req(4'd1, 27'h0000040, 1'b1, cce_pkg::CMD_ACK, 8'd2);
    add_req(4'd4, 27'h0002040, 1'b0, cce_pkg::CMD_GRANT, 8'd3);
    add_req(4'd5, 27'h00000c0, 1'b0, cce_pkg::CMD_GRANT, 8'd4);
    add_req(4'd2, 27'h0000080, 1'b1, cce_pkg::CMD_ACK, 8'd4);
    add_req(4'd6, 27'h0000080, 1'b0, cce_pkg::CMD_GRANT, 8'd5);
    add_req(4'd7, 27'h00010c0, 1'b0, cce_pkg::CMD_NACK, 8'd5);
    add_req(4'd15, 27'h7ffffc0, 1'b0, cce_pkg::CMD_GRANT, 8'd6);
    add_req(4'd0, 27'h0000400, 1'b0, cce_pkg::CMD_GRANT, 8'd7);
    add_req(4'd9, 27'h0003400, 1'b0, cce_pkg::CMD_NACK, 8'd7);
  endtask

  // Writes every word, then reads each one back
  task automatic load_ucode();
    for (int i = 0; i < ucode_tab.size(); i++) begin
      @(posedge clk);
      ucode_v     <= 1'b1;
      ucode_w     <= 1'b1;
      ucode_addr  <= i[cce_pkg::PC_WIDTH-1:0];
      ucode_wdata <= ucode_tab[i];
    end
    for (int i = 0; i < ucode_tab.size(); i++) begin
      @(posedge clk);
      ucode_w    <= 1'b0;
      ucode_addr <= i[cce_pkg::PC_WIDTH-1:0];
    end
    @(posedge clk);
    ucode_v <= 1'b0;
    @(posedge clk);
  endtask

  task automatic idle_gap(input int bits);
    int n;
    n = 0;
    for (int i = 0; i < bits; i++) begin
      gap_lfsr = lfsr_next(gap_lfsr);
      n = (n << 1) | gap_lfsr[0];
    end
    repeat (n) @(posedge clk);
  endtask

  task automatic send_req(input req_entry_s e, input int idx);
    int waited;
    waited = 0;
    @(posedge clk);
    req_hdr <= e.req;
    exp_cmd <= e.exp;
    req_v   <= 1'b1;
    @(posedge clk);
    while (!req_ready && waited < WAIT_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (!req_ready) begin
      timeouts++;
      $display("timeout: request %0d was never accepted", idx);
    end
    req_v <= 1'b0;
  endtask

  // Counts are read on the falling edge, after the checker has sampled
  task automatic wait_for_cmds();
    int waited;
    waited = 0;
    while (cmds < req_tab.size() && waited < DONE_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (cmds < req_tab.size()) begin
      timeouts++;
      $display("timeout: only %0d of %0d commands were sent", cmds, req_tab.size());
    end
  endtask

  task automatic finish_run();
    $display("errors: %0d mismatches, %0d other, %0d timeouts", mismatches, errors, timeouts);
    if (mismatches == 0 && errors == 0 && timeouts == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  // Command port back-pressure with ready about three cycles in four
  always @(posedge clk) begin
    if (reset) begin
      cmd_ready <= 1'b0;
    end else begin
      ready_lfsr = lfsr_next(ready_lfsr);
      ready_bit  = ready_lfsr[0];
      ready_lfsr = lfsr_next(ready_lfsr);
      cmd_ready <= ready_bit | ready_lfsr[0];
    end
  end

  initial begin
    reset       = 1'b1;
    run         = 1'b0;
    ucode_v     = 1'b0;
    ucode_w     = 1'b0;
    ucode_addr  = '0;
    ucode_wdata = '0;
    req_hdr     = '0;
    req_v       = 1'b0;
    exp_cmd     = '0;
    cmd_ready   = 1'b0;
    timeouts    = 0;
    gap_lfsr    = 32'd80027;
    ready_lfsr  = 32'd80027;
    build_tables();
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    load_ucode();
    run <= 1'b1;
    foreach (req_tab[i]) begin
      if (timeouts == 0) begin
        idle_gap(2);
        send_req(req_tab[i], i);
      end
    end
    if (timeouts == 0) begin
      wait_for_cmds();
    end
    finish_run();
  end

endmodule
